/* common/periph_defines.svh */
`ifndef PERIPH_DEFINES_SVH
`define PERIPH_DEFINES_SVH

// Number of timer channels behind the bridge
`define PERIPH_CHANNELS 4

// Bus widths
`define PERIPH_DATA_W 32
`define PERIPH_ADDR_W 28

// Channel select field of the near-side address
`define PERIPH_CHAN_LSB 24
`define PERIPH_CHAN_MSB 27

// Register select field, word aligned
`define PERIPH_REG_LSB 2
`define PERIPH_REG_MSB 3

// Bits between the register and channel fields must be zero
`define PERIPH_ZERO_LSB (`PERIPH_REG_MSB + 1)
`define PERIPH_ZERO_MSB (`PERIPH_CHAN_LSB - 1)

`endif

/* common/periph_pkg.sv */
`default_nettype none

`include "periph_defines.svh"

package periph_pkg;

	// ==================================================
	// Bus level types
	// ==================================================

	typedef logic [`PERIPH_DATA_W-1:0] word_t;

	// Wide enough to number every channel
	typedef logic [$clog2(`PERIPH_CHANNELS)-1:0] chan_id_t;

	// Register map of one timer channel
	typedef enum logic [1:0] {
		REG_CTRL    = 2'd0,
		REG_COMPARE = 2'd1,
		REG_COUNT   = 2'd2,
		REG_STATUS  = 2'd3
	} timer_reg_e;

	// ==================================================
	// Timer control word
	// ==================================================

	// Enable sits in bit 0, prescale in bits 10:3
	typedef struct packed {
		logic [20:0] reserved;
		logic [7:0]  prescale;
		logic        irq_enable;
		logic        auto_reload;
		logic        enable;
	} timer_ctrl_t;

	// Raw view for the bus, field view for the counter logic
	typedef union packed {
		word_t       raw;
		timer_ctrl_t fields;
	} timer_ctrl_u;

endpackage

`default_nettype wire

/* bridge/periph_bridge.sv */
`default_nettype none

`include "periph_defines.svh"

module periph_bridge import periph_pkg::*; (
	input  wire                      clock,
	input  wire                      i_rst_n,

	// Near side
	input  wire                      i_request,
	input  wire                      i_rw,
	input  wire [`PERIPH_ADDR_W-1:0] i_address,
	input  word_t                    i_wdata,
	output word_t                    o_rdata,
	output logic                     o_ready,

	// Far side
	input  word_t                    i_far_rdata,
	input  wire                      i_far_ready,
	output logic                     o_far_strobe,
	output logic [`PERIPH_CHANNELS-1:0] o_far_select,
	output logic                     o_far_rw,
	output timer_reg_e               o_far_reg,
	output word_t                    o_far_wdata
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAIT,
		ST_DONE
	} state_e;

	state_e state;

	logic [`PERIPH_CHAN_MSB-`PERIPH_CHAN_LSB:0] chan_field;
	logic                                       zero_bits_set;
	logic                                       mapped;
	logic [`PERIPH_CHANNELS-1:0]                select_next;

	// Stand-in for a channel response on unmapped accesses
	logic local_issue;
	logic local_ready;

	// ==================================================
	// Address decode
	// ==================================================

	assign chan_field    = i_address[`PERIPH_CHAN_MSB:`PERIPH_CHAN_LSB];
	assign zero_bits_set = |i_address[`PERIPH_ZERO_MSB:`PERIPH_ZERO_LSB];
	assign mapped        = !zero_bits_set && (chan_field < `PERIPH_CHANNELS);

	always_comb begin
		for (int i = 0; i < `PERIPH_CHANNELS; i++) begin
			select_next[i] = mapped && (chan_field == i);
		end
	end

	// ==================================================
	// Request FSM
	// ==================================================

	always_ff @(posedge clock) begin
		if (!i_rst_n) begin
			state        <= ST_IDLE;
			o_far_strobe <= 1'b0;
			o_far_select <= '0;
			local_issue  <= 1'b0;
			local_ready  <= 1'b0;
			o_ready      <= 1'b0;
		end else begin
			// Pulses default low
			o_far_strobe <= 1'b0;
			local_issue  <= 1'b0;
			local_ready  <= local_issue;
			o_ready      <= 1'b0;

			case (state)
				ST_IDLE: begin
					if (i_request) begin
						o_far_select <= select_next;
						// Unmapped writes never reach a channel
						o_far_strobe <= mapped;
						local_issue  <= !mapped;
						state        <= ST_WAIT;
					end
				end
				ST_WAIT: begin
					if (i_far_ready || local_ready) begin
						o_ready <= 1'b1;
						state   <= ST_DONE;
					end
				end
				ST_DONE: begin
					// Master drops the request while o_ready is seen
					state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Captured request and returned data
	always_ff @(posedge clock) begin
		if (state == ST_IDLE && i_request) begin
			o_far_rw    <= i_rw;
			o_far_reg   <= timer_reg_e'(i_address[`PERIPH_REG_MSB:`PERIPH_REG_LSB]);
			o_far_wdata <= i_wdata;
		end
		if (state == ST_WAIT && (i_far_ready || local_ready)) begin
			o_rdata <= local_ready ? '0 : i_far_rdata;
		end
	end

endmodule

`default_nettype wire

/* hw/timer_channel.sv */
`default_nettype none

`include "periph_defines.svh"

module timer_channel import periph_pkg::*; (
	input  wire        clock,
	input  wire        i_rst_n,

	// Far bus slice for this channel
	input  wire        i_strobe,
	input  wire        i_select,
	input  wire        i_rw,
	input  timer_reg_e i_reg,
	input  word_t      i_wdata,
	output word_t      o_rdata,
	output logic       o_ready,

	output logic       o_irq
);

	timer_ctrl_u ctrl;
	word_t       compare;
	word_t       count;
	logic        pending;
	logic [7:0]  prescale_cnt;

	logic        access;
	logic        write;
	logic        tick;
	word_t       read_word;

	assign access = i_strobe && i_select;
	assign write  = access && i_rw;

	// One tick every prescale+1 enabled cycles
	assign tick = ctrl.fields.enable && (prescale_cnt == ctrl.fields.prescale);

	assign o_irq = pending && ctrl.fields.irq_enable;

	// ==================================================
	// Prescaler
	// ==================================================

	always_ff @(posedge clock) begin
		if (!i_rst_n) begin
			prescale_cnt <= '0;
		end else if (!ctrl.fields.enable || tick) begin
			prescale_cnt <= '0;
		end else begin
			prescale_cnt <= prescale_cnt + 8'd1;
		end
	end

	// ==================================================
	// Counter and registers
	// ==================================================

	always_ff @(posedge clock) begin
		if (!i_rst_n) begin
			ctrl    <= '0;
			compare <= '0;
			count   <= '0;
			pending <= 1'b0;
		end else begin
			if (tick) begin
				if (count == compare) begin
					pending <= 1'b1;
					if (ctrl.fields.auto_reload) begin
						count <= '0;
					end else begin
						// One-shot stops here
						ctrl.fields.enable <= 1'b0;
					end
				end else begin
					count <= count + 1'b1;
				end
			end

			// Bus write wins over the tick for the same register
			if (write) begin
				case (i_reg)
					REG_CTRL:    ctrl.raw <= i_wdata;
					REG_COMPARE: compare  <= i_wdata;
					REG_COUNT:   count    <= i_wdata;
					REG_STATUS: begin
						if (i_wdata[0]) begin
							pending <= 1'b0;
						end
					end
					default: ;
				endcase
			end
		end
	end

	// ==================================================
	// Read response
	// ==================================================

	always_comb begin
		case (i_reg)
			REG_CTRL:    read_word = ctrl.raw;
			REG_COMPARE: read_word = compare;
			REG_COUNT:   read_word = count;
			REG_STATUS:  read_word = word_t'(pending);
			default:     read_word = '0;
		endcase
	end

	// Zero data outside a read response so the return OR stays clean
	always_ff @(posedge clock) begin
		if (!i_rst_n) begin
			o_ready <= 1'b0;
			o_rdata <= '0;
		end else begin
			o_ready <= access;
			o_rdata <= (access && !i_rw) ? read_word : '0;
		end
	end

endmodule

`default_nettype wire

/* hw/periph_return.sv */
`default_nettype none

`include "periph_defines.svh"

module periph_return import periph_pkg::*; (
	input  wire                                clock,
	input  wire                                i_rst_n,

	// Channel responses
	input  word_t [`PERIPH_CHANNELS-1:0]       i_chan_rdata,
	input  wire   [`PERIPH_CHANNELS-1:0]       i_chan_ready,
	input  wire   [`PERIPH_CHANNELS-1:0]       i_chan_irq,

	// Back to the bridge
	output word_t                              o_far_rdata,
	output logic                               o_far_ready,

	// Combined interrupt
	output logic                               o_interrupt,
	output chan_id_t                           o_irq_id
);

	chan_id_t irq_id_next;

	// ==================================================
	// Response merge
	// ==================================================

	// Idle channels drive zero, so a plain OR is enough
	always_comb begin
		o_far_rdata = '0;
		for (int i = 0; i < `PERIPH_CHANNELS; i++) begin
			o_far_rdata = o_far_rdata | i_chan_rdata[i];
		end
	end

	assign o_far_ready = |i_chan_ready;

	// ==================================================
	// Interrupt combine
	// ==================================================

	// Lowest numbered pending channel wins
	always_comb begin
		irq_id_next = '0;
		for (int i = `PERIPH_CHANNELS - 1; i >= 0; i--) begin
			if (i_chan_irq[i]) begin
				irq_id_next = chan_id_t'(i);
			end
		end
	end

	always_ff @(posedge clock) begin
		if (!i_rst_n) begin
			o_interrupt <= 1'b0;
			o_irq_id    <= '0;
		end else begin
			o_interrupt <= |i_chan_irq;
			o_irq_id    <= irq_id_next;
		end
	end

endmodule

`default_nettype wire

/* hw/periph_subsystem.sv */
`default_nettype none

`include "periph_defines.svh"

module periph_subsystem import periph_pkg::*; (
	input  wire                      clock,
	input  wire                      i_rst_n,

	// Near-side bus
	input  wire                      i_request,
	input  wire                      i_rw,
	input  wire [`PERIPH_ADDR_W-1:0] i_address,
	input  word_t                    i_wdata,
	output word_t                    o_rdata,
	output logic                     o_ready,

	// Interrupt to the CPU
	output logic                     o_interrupt,
	output chan_id_t                 o_irq_id
);

	// Far bus
	logic                        far_strobe;
	logic [`PERIPH_CHANNELS-1:0] far_select;
	logic                        far_rw;
	timer_reg_e                  far_reg;
	word_t                       far_wdata;
	word_t                       far_rdata;
	logic                        far_ready;

	// Per channel responses
	word_t [`PERIPH_CHANNELS-1:0] chan_rdata;
	logic  [`PERIPH_CHANNELS-1:0] chan_ready;
	logic  [`PERIPH_CHANNELS-1:0] chan_irq;

	// ==================================================
	// Bridge
	// ==================================================

	periph_bridge periph_bridge_inst (
		.clock        (clock),
		.i_rst_n      (i_rst_n),
		.i_request    (i_request),
		.i_rw         (i_rw),
		.i_address    (i_address),
		.i_wdata      (i_wdata),
		.o_rdata      (o_rdata),
		.o_ready      (o_ready),
		.i_far_rdata  (far_rdata),
		.i_far_ready  (far_ready),
		.o_far_strobe (far_strobe),
		.o_far_select (far_select),
		.o_far_rw     (far_rw),
		.o_far_reg    (far_reg),
		.o_far_wdata  (far_wdata)
	);

	// ==================================================
	// Timer channels
	// ==================================================

	for (genvar g = 0; g < `PERIPH_CHANNELS; g++) begin : gen_chan
		timer_channel timer_channel_inst (
			.clock    (clock),
			.i_rst_n  (i_rst_n),
			.i_strobe (far_strobe),
			.i_select (far_select[g]),
			.i_rw     (far_rw),
			.i_reg    (far_reg),
			.i_wdata  (far_wdata),
			.o_rdata  (chan_rdata[g]),
			.o_ready  (chan_ready[g]),
			.o_irq    (chan_irq[g])
		);
	end

	// Response and interrupt collection
	periph_return periph_return_inst (
		.clock        (clock),
		.i_rst_n      (i_rst_n),
		.i_chan_rdata (chan_rdata),
		.i_chan_ready (chan_ready),
		.i_chan_irq   (chan_irq),
		.o_far_rdata  (far_rdata),
		.o_far_ready  (far_ready),
		.o_interrupt  (o_interrupt),
		.o_irq_id     (o_irq_id)
	);

endmodule

`default_nettype wire

/* testbench/tb_periph_tests.svh */
`ifndef TB_PERIPH_TESTS_SVH
`define TB_PERIPH_TESTS_SVH

// Register contents the channels should hold after the first test
word_t       exp_compare [`PERIPH_CHANNELS];
word_t       exp_count   [`PERIPH_CHANNELS];
timer_ctrl_u exp_ctrl    [`PERIPH_CHANNELS];

function automatic logic [`PERIPH_ADDR_W-1:0] reg_address(input int chan, input timer_reg_e sel);
	logic [`PERIPH_ADDR_W-1:0] addr;
	addr = '0;
	addr[`PERIPH_CHAN_MSB:`PERIPH_CHAN_LSB] = 4'(chan);
	addr[`PERIPH_REG_MSB:`PERIPH_REG_LSB]   = sel;
	return addr;
endfunction

// Enabled control word
function automatic timer_ctrl_u make_ctrl(input logic [7:0] prescale, input logic irq_enable,
		input logic auto_reload);
	timer_ctrl_u ctrl;
	ctrl.raw                = '0;
	ctrl.fields.enable      = 1'b1;
	ctrl.fields.auto_reload = auto_reload;
	ctrl.fields.irq_enable  = irq_enable;
	ctrl.fields.prescale    = prescale;
	return ctrl;
endfunction

// Stop, clear pending and count, then start with the given setup
task automatic start_timer(input int chan, input word_t compare, input timer_ctrl_u ctrl);
	bus_write(reg_address(chan, REG_CTRL), '0);
	bus_write(reg_address(chan, REG_STATUS), 32'd1);
	bus_write(reg_address(chan, REG_COUNT), '0);
	bus_write(reg_address(chan, REG_COMPARE), compare);
	bus_write(reg_address(chan, REG_CTRL), ctrl.raw);
endtask

task automatic verify_registers();
	word_t       data;
	timer_ctrl_u ctrl;
	for (int ch = 0; ch < `PERIPH_CHANNELS; ch++) begin
		bus_read(reg_address(ch, REG_CTRL), data);
		ctrl.raw = data;
		check_ctrl($sformatf("ctrl[%0d]", ch), exp_ctrl[ch], ctrl);
		bus_read(reg_address(ch, REG_COMPARE), data);
		check_word($sformatf("compare[%0d]", ch), exp_compare[ch], data);
		bus_read(reg_address(ch, REG_COUNT), data);
		check_word($sformatf("count[%0d]", ch), exp_count[ch], data);
	end
endtask

// ==================================================
// Directed tests
// ==================================================

task automatic register_access();
	for (int ch = 0; ch < `PERIPH_CHANNELS; ch++) begin
		exp_ctrl[ch].raw           = next_random();
		exp_ctrl[ch].fields.enable = 1'b0;
		exp_compare[ch]            = next_random();
		exp_count[ch]              = next_random();
		bus_write(reg_address(ch, REG_CTRL), exp_ctrl[ch].raw);
		bus_write(reg_address(ch, REG_COMPARE), exp_compare[ch]);
		bus_write(reg_address(ch, REG_COUNT), exp_count[ch]);
	end
	verify_registers();
endtask

task automatic unmapped_access();
	logic [`PERIPH_ADDR_W-1:0] addr;
	word_t                     data;
	addr     = reg_address(1, REG_COMPARE);
	addr[12] = 1'b1;
	bus_read(addr, data);
	check_word("o_rdata unmapped", '0, data);
	// Both writes would hit channel 1 without the stray bit
	addr     = reg_address(1, REG_COMPARE);
	addr[20] = 1'b1;
	bus_write(addr, next_random());
	addr    = reg_address(1, REG_COUNT);
	addr[4] = 1'b1;
	bus_write(addr, next_random());
	verify_registers();
endtask

task automatic one_shot_timer();
	timer_ctrl_u ctrl;
	timer_ctrl_u read_ctrl;
	word_t       data;
	ctrl = make_ctrl(8'd2, 1'b1, 1'b0);
	start_timer(2, 32'd6, ctrl);
	wait_interrupt(1'b1);
	check_id("o_irq_id", 2'd2, o_irq_id);
	bus_read(reg_address(2, REG_COUNT), data);
	check_word("count[2]", 32'd6, data);
	ctrl.fields.enable = 1'b0;
	bus_read(reg_address(2, REG_CTRL), data);
	read_ctrl.raw = data;
	check_ctrl("ctrl[2]", ctrl, read_ctrl);
	bus_read(reg_address(2, REG_STATUS), data);
	check_word("status[2]", 32'd1, data);
	bus_write(reg_address(2, REG_STATUS), 32'd1);
	wait_interrupt(1'b0);
endtask

task automatic auto_reload_clear();
	word_t data;
	start_timer(0, 32'd20, make_ctrl(8'd3, 1'b1, 1'b1));
	wait_interrupt(1'b1);
	check_id("o_irq_id", 2'd0, o_irq_id);
	bus_write(reg_address(0, REG_STATUS), 32'd1);
	wait_interrupt(1'b0);
	wait_interrupt(1'b1);
	bus_read(reg_address(0, REG_COUNT), data);
	if (data > 32'd20) begin
		abort_run($sformatf("ERROR at %0t: count[0] expected at most 20 got %0d", $time, data));
	end
	bus_write(reg_address(0, REG_CTRL), '0);
	bus_write(reg_address(0, REG_STATUS), 32'd1);
	wait_interrupt(1'b0);
endtask

task automatic irq_priority();
	word_t data;
	start_timer(3, '0, make_ctrl(8'd0, 1'b1, 1'b0));
	start_timer(1, '0, make_ctrl(8'd0, 1'b1, 1'b0));
	bus_read(reg_address(3, REG_STATUS), data);
	check_word("status[3]", 32'd1, data);
	bus_read(reg_address(1, REG_STATUS), data);
	check_word("status[1]", 32'd1, data);
	check_bit("o_interrupt", 1'b1, o_interrupt);
	check_id("o_irq_id", 2'd1, o_irq_id);
	bus_write(reg_address(1, REG_STATUS), 32'd1);
	check_id("o_irq_id", 2'd3, o_irq_id);
	bus_write(reg_address(3, REG_STATUS), 32'd1);
	check_bit("o_interrupt", 1'b0, o_interrupt);
endtask

// Pending without irq_enable stays off the line
task automatic irq_masking();
	word_t data;
	start_timer(2, '0, make_ctrl(8'd0, 1'b0, 1'b0));
	bus_read(reg_address(2, REG_STATUS), data);
	check_word("status[2]", 32'd1, data);
	check_bit("o_interrupt", 1'b0, o_interrupt);
	bus_write(reg_address(2, REG_STATUS), 32'd1);
endtask

`endif

/* testbench/tb_periph_subsystem.sv */
`default_nettype none

`include "periph_defines.svh"

module tb_periph_subsystem import periph_pkg::*; ();

	localparam int BUS_TIMEOUT = 50;
	localparam int IRQ_TIMEOUT = 1000;

	logic                      clock;
	logic                      i_rst_n;
	logic                      i_request;
	logic                      i_rw;
	logic [`PERIPH_ADDR_W-1:0] i_address;
	word_t                     i_wdata;
	word_t                     o_rdata;
	logic                      o_ready;
	logic                      o_interrupt;
	chan_id_t                  o_irq_id;

	logic [31:0]               rng_state;

	periph_subsystem periph_subsystem_inst (
		.clock       (clock),
		.i_rst_n     (i_rst_n),
		.i_request   (i_request),
		.i_rw        (i_rw),
		.i_address   (i_address),
		.i_wdata     (i_wdata),
		.o_rdata     (o_rdata),
		.o_ready     (o_ready),
		.o_interrupt (o_interrupt),
		.o_irq_id    (o_irq_id)
	);

	always #5 clock = ~clock;

	// ==================================================
	// Reporting and compare tasks
	// ==================================================

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("Something failed");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			abort_run($sformatf("ERROR at %0t: %s expected %h got %h",
				$time, name, expected, actual));
		end
	endtask

	task automatic check_ctrl(input string name, input timer_ctrl_u expected,
			input timer_ctrl_u actual);
		if (actual !== expected) begin
			abort_run($sformatf({"ERROR at %0t: %s expected enable=%0b auto_reload=%0b ",
				"irq_enable=%0b prescale=%0d reserved=%h got enable=%0b auto_reload=%0b ",
				"irq_enable=%0b prescale=%0d reserved=%h"}, $time, name,
				expected.fields.enable, expected.fields.auto_reload,
				expected.fields.irq_enable, expected.fields.prescale,
				expected.fields.reserved, actual.fields.enable, actual.fields.auto_reload,
				actual.fields.irq_enable, actual.fields.prescale, actual.fields.reserved));
		end
	endtask

	task automatic check_id(input string name, input chan_id_t expected, input chan_id_t actual);
		if (actual !== expected) begin
			abort_run($sformatf("ERROR at %0t: %s expected %0d got %0d",
				$time, name, expected, actual));
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			abort_run($sformatf("ERROR at %0t: %s expected %0b got %0b",
				$time, name, expected, actual));
		end
	endtask

	// xorshift32
	function automatic word_t next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// ==================================================
	// Bus and wait helpers
	// ==================================================

	// Outputs are sampled on the falling edge
	task automatic bus_access(input logic rw, input logic [`PERIPH_ADDR_W-1:0] addr,
			input word_t wdata, output word_t rdata);
		int edges;
		@(posedge clock);
		i_request <= 1'b1;
		i_rw      <= rw;
		i_address <= addr;
		i_wdata   <= wdata;
		edges = 0;
		@(negedge clock);
		while (!o_ready && edges < BUS_TIMEOUT) begin
			@(negedge clock);
			edges++;
		end
		if (!o_ready) begin
			abort_run("Timeout waiting for o_ready on the near-side bus");
		end
		// Accepted on the first edge, ready after the third
		if (edges != 3) begin
			abort_run($sformatf("ERROR at %0t: o_ready latency expected 3 edges got %0d",
				$time, edges));
		end
		rdata = o_rdata;
		@(posedge clock);
		i_request <= 1'b0;
		@(negedge clock);
	endtask

	task automatic bus_write(input logic [`PERIPH_ADDR_W-1:0] addr, input word_t data);
		word_t unused;
		bus_access(1'b1, addr, data, unused);
	endtask

	task automatic bus_read(input logic [`PERIPH_ADDR_W-1:0] addr, output word_t data);
		bus_access(1'b0, addr, '0, data);
	endtask

	task automatic wait_interrupt(input logic level);
		int cycles;
		cycles = 0;
		while (o_interrupt !== level && cycles < IRQ_TIMEOUT) begin
			@(negedge clock);
			cycles++;
		end
		if (o_interrupt !== level) begin
			abort_run($sformatf("Timeout waiting for o_interrupt to become %0b", level));
		end
	endtask

	`include "tb_periph_tests.svh"

	// ==================================================
	// Test sequence
	// ==================================================

	initial begin
		rng_state = 32'hf61a_bd09;
		clock     = 1'b0;
		i_rst_n   = 1'b0;
		i_request = 1'b0;
		i_rw      = 1'b0;
		i_address = '0;
		i_wdata   = '0;
		repeat (8) @(posedge clock);
		i_rst_n <= 1'b1;
		@(negedge clock);

		check_bit("o_ready", 1'b0, o_ready);
		check_bit("o_interrupt", 1'b0, o_interrupt);
		check_id("o_irq_id", '0, o_irq_id);

		register_access();
		unmapped_access();
		one_shot_timer();
		auto_reload_clear();
		irq_priority();
		irq_masking();

		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
+incdir+common
+incdir+testbench
common/periph_pkg.sv
bridge/periph_bridge.sv
hw/timer_channel.sv
hw/periph_return.sv
hw/periph_subsystem.sv
testbench/tb_periph_subsystem.sv
